//--- hdl/jag_pkg.sv
`default_nettype none

package jag_pkg;

	// Serial EEPROM, 64 x 16
	localparam int EE_WORDS = 64;

	typedef logic [15:0] ee_word_t;          // One stored word
	typedef logic [5:0]  ee_addr_t;          // Word address
	typedef logic [8:0]  ee_instr_t;         // Start bit, opcode, address

	localparam ee_word_t EE_ERASED = 16'hFFFF; // Erased cell value

	// Opcode field
	localparam logic [1:0] EE_OP_EXT   = 2'b00; // Extended, decoded from address top
	localparam logic [1:0] EE_OP_WRITE = 2'b01;
	localparam logic [1:0] EE_OP_READ  = 2'b10;
	localparam logic [1:0] EE_OP_ERASE = 2'b11;

	// Extended opcodes in address bits 5:4
	localparam logic [1:0] EE_EXT_EWDS = 2'b00;
	localparam logic [1:0] EE_EXT_WRAL = 2'b01;
	localparam logic [1:0] EE_EXT_ERAL = 2'b10;
	localparam logic [1:0] EE_EXT_EWEN = 2'b11;

	// Top bit set on internal write states
	typedef enum logic [2:0] {
		IDLE     = 3'b000,
		DATA     = 3'b001,
		READ     = 3'b010,
		WR_BEGIN = 3'b100,
		WR_WRITE = 3'b101,
		WR_LOOP  = 3'b110,
		WR_END   = 3'b111
	} ee_state_e;

	typedef struct packed {
		logic cs;                            // Chip select
		logic sk;                            // Serial clock
		logic di;                            // Serial data in
	} ee_pins_t;

	// I2S audio
	localparam int I2S_BITS  = 16;
	localparam int I2S_CNT_W = $clog2(I2S_BITS + 1); // Room for the overflow count

	typedef logic signed [15:0] audio_sample_t;

	typedef struct packed {
		logic sck;
		logic ws;                            // Low selects left
		logic sd;
	} i2s_pins_t;

	typedef struct packed {
		audio_sample_t left;
		audio_sample_t right;
	} stereo_t;

	// Analog joystick ADC
	typedef logic [7:0] analog_t;            // Unsigned stick position
	typedef logic [3:0] adc_sel_t;           // Mode in 3:2, channel in 1:0

	typedef struct packed {
		analog_t ch0;
		analog_t ch1;
		analog_t ch2;
		analog_t ch3;
	} analog_quad_t;

endpackage

`default_nettype wire

//--- hdl/ee_word_store.sv
`timescale 1ns/10ps
`default_nettype none

module ee_word_store (
	input  wire logic              sys_clk,
	input  wire jag_pkg::ee_addr_t addr_i,
	input  wire jag_pkg::ee_word_t wdata_i,
	input  wire logic              wr_i,
	output jag_pkg::ee_word_t      rdata_o
);

	jag_pkg::ee_word_t mem [jag_pkg::EE_WORDS];

	// Blank device at power up
	initial begin
		for (int i = 0; i < jag_pkg::EE_WORDS; i++) begin
			mem[i] = jag_pkg::EE_ERASED;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	assign rdata_o = mem[addr_i];        // Asynchronous read

	assert property (@(posedge sys_clk) wr_i |-> !$isunknown(addr_i));

endmodule

`default_nettype wire

//--- hdl/ee_serial_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ee_serial_ctrl (
	input  wire logic              sys_clk,
	input  wire logic              xresetl,
	input  wire jag_pkg::ee_pins_t ee_i,
	output logic                   ee_do_o,
	output jag_pkg::ee_addr_t      mem_addr_o,
	output jag_pkg::ee_word_t      mem_wdata_o,
	output logic                   mem_wr_o,
	input  wire jag_pkg::ee_word_t mem_rdata_i
);

	jag_pkg::ee_pins_t  pins_q;          // Sampled pins
	logic               sk_prev;
	logic               sk_rise;
	jag_pkg::ee_state_e state;
	logic               ewen;            // Write enable latch
	logic [3:0]         cnt;             // Data bit count
	jag_pkg::ee_instr_t ir;              // Instruction register
	jag_pkg::ee_word_t  dr;              // Data shift register
	jag_pkg::ee_addr_t  wraddr;          // Sequencer address
	jag_pkg::ee_word_t  wrdata;          // Sequencer data
	logic               wrloop;          // Whole array pass
	logic               wr_erase;

	assign sk_rise = pins_q.sk & ~sk_prev;

	// Erase variants write the blank pattern
	assign wr_erase = (ir[7:6] == jag_pkg::EE_OP_ERASE) ||
		(ir[7:6] == jag_pkg::EE_OP_EXT && ir[5:4] == jag_pkg::EE_EXT_ERAL);

	// Read address is the five shifted bits plus the incoming one
	assign mem_addr_o  = state[2] ? wraddr : {ir[4:0], pins_q.di};
	assign mem_wdata_o = wrdata;
	assign mem_wr_o    = (state == jag_pkg::WR_WRITE) && ewen; // Protected when latch clear

	always_ff @(posedge sys_clk) begin
		pins_q  <= ee_i;
		sk_prev <= pins_q.sk;
		if (!xresetl) begin
			state   <= jag_pkg::IDLE;
			ewen    <= 1'b0;
			cnt     <= '0;
			ir      <= '0;
			wrloop  <= 1'b0;
			ee_do_o <= 1'b1;
		end else if (!pins_q.cs) begin
			// Deselected but the latch is kept
			state   <= jag_pkg::IDLE;
			cnt     <= '0;
			ir      <= '0;
			wrloop  <= 1'b0;
			ee_do_o <= 1'b1;
		end else if (state[2]) begin
			// Internal write sequence runs without sk
			case (state)
				jag_pkg::WR_BEGIN: begin
					ee_do_o <= 1'b0;                       // Busy
					wrloop  <= (ir[7:6] == jag_pkg::EE_OP_EXT);
					wraddr  <= (ir[7:6] == jag_pkg::EE_OP_EXT) ? '0 : ir[5:0];
					wrdata  <= wr_erase ? jag_pkg::EE_ERASED : dr;
					state   <= jag_pkg::WR_WRITE;
				end
				jag_pkg::WR_WRITE: state <= jag_pkg::WR_LOOP; // Strobe in this cycle
				jag_pkg::WR_LOOP: begin
					if (!wrloop || &wraddr) begin
						state <= jag_pkg::WR_END;
					end else begin
						wraddr <= wraddr + 1'b1;
						state  <= jag_pkg::WR_WRITE;
					end
				end
				default: begin
					ee_do_o <= 1'b1;                       // Ready
					state   <= jag_pkg::IDLE;
				end
			endcase
		end else if (sk_rise) begin
			case (state)
				jag_pkg::IDLE: begin
					ir <= {ir[7:0], pins_q.di};
					if (ir[7]) begin                     // Start bit reaches the top
						case (ir[6:5])
							jag_pkg::EE_OP_READ: begin
								dr      <= mem_rdata_i;
								ee_do_o <= 1'b0;             // Dummy zero
								state   <= jag_pkg::READ;
							end
							jag_pkg::EE_OP_WRITE: state <= jag_pkg::DATA;
							jag_pkg::EE_OP_ERASE: state <= jag_pkg::WR_BEGIN;
							default: begin
								case (ir[4:3])
									jag_pkg::EE_EXT_EWEN: ewen  <= 1'b1;
									jag_pkg::EE_EXT_EWDS: ewen  <= 1'b0;
									jag_pkg::EE_EXT_ERAL: state <= jag_pkg::WR_BEGIN;
									default:              state <= jag_pkg::DATA; // WRAL
								endcase
							end
						endcase
					end
				end
				jag_pkg::DATA: begin
					dr  <= {dr[14:0], pins_q.di};        // MSB first
					cnt <= cnt + 1'b1;
					if (&cnt) begin
						state <= jag_pkg::WR_BEGIN;
					end
				end
				default: begin
					ee_do_o <= dr[15];                   // Shift out word
					dr      <= {dr[14:0], 1'b0};
				end
			endcase
		end
	end

	// Strobe only in a WR_WRITE entered from WR_BEGIN or WR_LOOP
	assert property (@(posedge sys_clk) disable iff (!xresetl)
		mem_wr_o |-> (state == jag_pkg::WR_WRITE) &&
			($past(state) == jag_pkg::WR_BEGIN || $past(state) == jag_pkg::WR_LOOP));

	assert property (@(posedge sys_clk) disable iff (!xresetl)
		!$isunknown(state));

endmodule

`default_nettype wire

//--- hdl/analog_adc.sv
`timescale 1ns/10ps
`default_nettype none

module analog_adc (
	input  wire logic                  sys_clk,
	input  wire logic                  xresetl,
	input  wire logic                  adc_wr_i,
	input  wire jag_pkg::adc_sel_t     adc_sel_i,
	input  wire jag_pkg::analog_quad_t analog_i,
	output jag_pkg::analog_t           adc_data_o
);

	jag_pkg::analog_t ch [4];            // Channels by index
	jag_pkg::analog_t result;
	logic [1:0]       mode;
	logic [1:0]       chan;

	// Difference clamped at zero
	function automatic jag_pkg::analog_t sat_sub(input jag_pkg::analog_t a,
		input jag_pkg::analog_t b);
		return (a < b) ? '0 : a - b;
	endfunction

	assign ch[0] = analog_i.ch0;
	assign ch[1] = analog_i.ch1;
	assign ch[2] = analog_i.ch2;
	assign ch[3] = analog_i.ch3;
	assign mode  = adc_sel_i[3:2];
	assign chan  = adc_sel_i[1:0];

	always_comb begin
		case (mode)
			2'd1:    result = ch[chan];                                // Raw
			2'd3:    result = (chan == 2'd3) ? adc_data_o : sat_sub(ch[chan], ch[3]);
			default: result = sat_sub(ch[chan], ch[{chan[1], ~chan[0]}]); // Pair partner
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			adc_data_o <= '0;
		end else if (adc_wr_i) begin
			adc_data_o <= result;
		end
	end

endmodule

`default_nettype wire

//--- hdl/audio_enable_gate.sv
`timescale 1ns/10ps
`default_nettype none

module audio_enable_gate (
	input  wire logic               sys_clk,
	input  wire logic               xresetl,
	input  wire logic               aud_en_wr_i,
	input  wire logic               aud_en_d_i,
	input  wire jag_pkg::i2s_pins_t i2s_i,
	output logic                    qws_o
);

	logic wr_prev;
	logic sck_prev;
	logic sck_rise;
	logic aud_en;                        // Enable latch
	logic ws_q;

	assign sck_rise = i2s_i.sck & ~sck_prev;

	always_ff @(posedge sys_clk) begin
		wr_prev  <= aud_en_wr_i;
		sck_prev <= i2s_i.sck;
		if (!xresetl) begin
			aud_en <= 1'b0;
		end else if (aud_en_wr_i & ~wr_prev) begin
			aud_en <= aud_en_d_i;            // Rising edge of the write strobe
		end
		if (!aud_en) begin
			ws_q <= 1'b0;                    // Held clear while disabled
		end else if (sck_rise) begin
			ws_q <= i2s_i.ws;
		end
	end

	// New ws passes straight through on the sck edge
	assign qws_o = aud_en & (sck_rise ? i2s_i.ws : ws_q);

endmodule

`default_nettype wire

//--- hdl/i2s_capture.sv
`timescale 1ns/10ps
`default_nettype none

module i2s_capture (
	input  wire logic         sys_clk,
	input  wire logic         xresetl,
	input  wire logic         sck_i,
	input  wire logic         sd_i,
	input  wire logic         ws_i,
	output jag_pkg::stereo_t  audio_o
);

	jag_pkg::audio_sample_t         buf_q [2]; // Left and right being filled
	logic [jag_pkg::I2S_CNT_W-1:0]  cnt_q;     // Bits taken this word
	logic                           sck_prev;
	logic                           ws_prev;
	logic                           side_q;    // Buffer in use
	logic                           next_q;    // Word select changed

	always_ff @(posedge sys_clk) begin
		sck_prev <= sck_i;
		if (!xresetl) begin
			ws_prev  <= ws_i;
			side_q   <= ws_i;
			cnt_q    <= '0;
			next_q   <= 1'b0;
			buf_q[0] <= '0;
			buf_q[1] <= '0;
			audio_o  <= '0;
		end else begin
			// Data on falling sck
			if (!sck_i && sck_prev) begin
				if (cnt_q < jag_pkg::I2S_BITS) begin // Overflow bits dropped
					cnt_q <= cnt_q + 1'b1;
					buf_q[side_q][jag_pkg::I2S_BITS - 1 - cnt_q] <= sd_i;
				end
				ws_prev <= ws_i;
				if (ws_prev != ws_i) begin
					next_q <= 1'b1;
				end
			end
			// Word boundary on rising sck
			if (sck_i && !sck_prev && next_q) begin
				cnt_q  <= '0;
				side_q <= ws_i;
				next_q <= 1'b0;
				if (!ws_i) begin                 // Back to left, frame done
					audio_o.left  <= buf_q[0];
					audio_o.right <= buf_q[1];
					buf_q[0]      <= '0;
					buf_q[1]      <= '0;
				end
			end
		end
	end

	assert property (@(posedge sys_clk) disable iff (!xresetl)
		cnt_q <= jag_pkg::I2S_BITS);

endmodule

`default_nettype wire

//--- hdl/jag_periph_top.sv
`timescale 1ns/10ps
`default_nettype none

module jag_periph_top (
	input  wire logic                  sys_clk,
	input  wire logic                  xresetl,
	input  wire jag_pkg::ee_pins_t     ee_i,
	output wire logic                  ee_do_o,
	input  wire logic                  adc_wr_i,
	input  wire jag_pkg::adc_sel_t     adc_sel_i,
	input  wire jag_pkg::analog_quad_t analog_i,
	output wire jag_pkg::analog_t      adc_data_o,
	input  wire logic                  aud_en_wr_i,
	input  wire logic                  aud_en_d_i,
	input  wire jag_pkg::i2s_pins_t    i2s_i,
	output wire jag_pkg::stereo_t      audio_o
);

	wire jag_pkg::ee_addr_t ee_addr;     // Word store address
	wire jag_pkg::ee_word_t ee_wdata;
	wire jag_pkg::ee_word_t ee_rdata;
	wire logic              ee_wr;
	wire logic              qws;         // Gated word select

	// EEPROM controller and its storage
	ee_serial_ctrl u_ee_serial_ctrl (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.ee_i        (ee_i),
		.ee_do_o     (ee_do_o),
		.mem_addr_o  (ee_addr),
		.mem_wdata_o (ee_wdata),
		.mem_wr_o    (ee_wr),
		.mem_rdata_i (ee_rdata)
	);

	ee_word_store u_ee_word_store (
		.sys_clk (sys_clk),
		.addr_i  (ee_addr),
		.wdata_i (ee_wdata),
		.wr_i    (ee_wr),
		.rdata_o (ee_rdata)
	);

	analog_adc u_analog_adc (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.adc_wr_i   (adc_wr_i),
		.adc_sel_i  (adc_sel_i),
		.analog_i   (analog_i),
		.adc_data_o (adc_data_o)
	);

	// Audio path, enable gate ahead of the deserializer
	audio_enable_gate u_audio_enable_gate (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.aud_en_wr_i (aud_en_wr_i),
		.aud_en_d_i  (aud_en_d_i),
		.i2s_i       (i2s_i),
		.qws_o       (qws)
	);

	i2s_capture u_i2s_capture (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.sck_i   (i2s_i.sck),
		.sd_i    (i2s_i.sd),
		.ws_i    (qws),
		.audio_o (audio_o)
	);

endmodule

`default_nettype wire

//--- testbench/jag_periph_checker.sv
`timescale 1ns/10ps
`default_nettype none

module jag_periph_checker (
	input  wire logic             sys_clk,
	input  wire logic             ee_do_i,
	input  wire jag_pkg::analog_t adc_data_i,
	input  wire jag_pkg::stereo_t audio_i,
	input  wire logic             ee_bit_i,    // Grab ee_do into the shift register
	input  wire logic             chk_i,       // Compare this cycle
	input  wire logic [1:0]       kind_i,      // 0 do pin, 1 EE read, 2 ADC, 3 audio
	input  wire logic [31:0]      exp_i,
	input  wire logic [159:0]     name_i,
	output logic [31:0]           errors_o,
	output logic [31:0]           checks_o
);

	logic [16:0] ee_sr;                      // Dummy bit plus read word
	logic [31:0] actual;

	initial begin
		errors_o = 0;
		checks_o = 0;
		ee_sr    = '0;
	end

	always_comb begin
		case (kind_i)
			2'd0:    actual = {31'd0, ee_do_i};
			2'd1:    actual = {15'd0, ee_sr};
			2'd2:    actual = {24'd0, adc_data_i};
			default: actual = audio_i;
		endcase
	end

	always @(posedge sys_clk) begin
		if (ee_bit_i) begin
			ee_sr <= {ee_sr[15:0], ee_do_i};
		end
		if (chk_i) begin
			checks_o <= checks_o + 1;
			if (actual !== exp_i) begin
				errors_o <= errors_o + 1;
				$display("[FAIL] %0s expected %h actual %h", name_i, exp_i, actual);
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_jag_periph.sv
`timescale 1ns/10ps
`default_nettype none

module tb_jag_periph;

	logic                  sys_clk;
	logic                  xresetl;
	jag_pkg::ee_pins_t     ee;
	logic                  ee_do;
	logic                  adc_wr;
	jag_pkg::adc_sel_t     adc_sel;
	jag_pkg::analog_quad_t analog;
	jag_pkg::analog_t      adc_data;
	logic                  aud_en_wr;
	logic                  aud_en_d;
	jag_pkg::i2s_pins_t    i2s;
	jag_pkg::stereo_t      audio;
	logic                  ee_bit;
	logic                  chk;
	logic [1:0]            chk_kind;
	logic [31:0]           chk_exp;
	logic [159:0]          chk_name;
	logic [31:0]           errors;
	logic [31:0]           checks;

	// Case table
	logic [159:0]          case_name [64];
	logic [31:0]           case_kind [64];
	logic [31:0]           f1 [64];
	logic [31:0]           f2 [64];
	logic [31:0]           f3 [64];
	int                    n_cases;
	int                    issued;           // Compares requested from the checker
	int                    setup_errors;     // Case file and case kind problems
	int unsigned           cycles;
	int unsigned           limit = 100;

	jag_periph_top u_jag_periph_top (
		.sys_clk (sys_clk), .xresetl (xresetl), .ee_i (ee), .ee_do_o (ee_do),
		.adc_wr_i (adc_wr), .adc_sel_i (adc_sel), .analog_i (analog),
		.adc_data_o (adc_data), .aud_en_wr_i (aud_en_wr), .aud_en_d_i (aud_en_d),
		.i2s_i (i2s), .audio_o (audio)
	);

	jag_periph_checker u_checker (
		.sys_clk (sys_clk), .ee_do_i (ee_do), .adc_data_i (adc_data), .audio_i (audio),
		.ee_bit_i (ee_bit), .chk_i (chk), .kind_i (chk_kind), .exp_i (chk_exp),
		.name_i (chk_name), .errors_o (errors), .checks_o (checks)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Test timed out after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic load_cases();
		int    fd;
		string line;
		logic [159:0] nm;
		logic [31:0]  kd, a, b, c;
		n_cases = 0;
		fd = $fopen("testbench/periph_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/periph_cases.txt");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#" && n_cases < 64) begin
					if ($sscanf(line, "%s %s %h %h %h", nm, kd, a, b, c) == 5) begin
						case_name[n_cases] = nm;
						case_kind[n_cases] = kd;
						f1[n_cases]        = a;
						f2[n_cases]        = b;
						f3[n_cases]        = c;
						n_cases++;
					end else begin
						$display("Malformed line in case file: %0s", line);
						setup_errors++;
					end
				end
			end
			$fclose(fd);
			if (n_cases == 0) begin
				$display("No cases found in testbench/periph_cases.txt");
				setup_errors++;
			end
		end
	endtask

	task automatic check(input logic [1:0] kind, input logic [31:0] expv,
		input logic [159:0] nm);
		chk      = 1'b1;
		chk_kind = kind;
		chk_exp  = expv;
		chk_name = nm;
		issued++;
		@(negedge sys_clk);
		chk      = 1'b0;
	endtask

	// One sk period with an optional grab of ee_do at its end
	task automatic ee_clock(input logic b, input logic grab);
		@(negedge sys_clk);
		ee.sk  = 1'b0;
		ee.di  = b;
		ee_bit = 1'b0;
		repeat (4) @(negedge sys_clk);
		ee.sk = 1'b1;
		repeat (3) @(negedge sys_clk);
		ee_bit = grab;                       // ee_do settled two clocks ago
	endtask

	task automatic ee_case(input int i);
		logic [1:0] op;
		logic [1:0] ext;
		logic       is_read;
		op      = f1[i][7:6];
		ext     = f1[i][5:4];
		is_read = (op == 2'b10);
		@(negedge sys_clk);
		ee.cs = 1'b1;
		repeat (2) @(negedge sys_clk);
		for (int k = 8; k >= 0; k--) begin
			ee_clock(f1[i][k], is_read && k == 0); // Dummy zero grabbed after last bit
		end
		if (op == 2'b01 || (op == 2'b00 && ext == 2'b01)) begin
			for (int k = 15; k >= 0; k--) begin
				ee_clock(f2[i][k], 1'b0);        // Data MSB first
			end
		end
		if (is_read) begin
			for (int k = 0; k < 16; k++) begin
				ee_clock(1'b0, 1'b1);
			end
			@(negedge sys_clk);
			ee_bit = 1'b0;
			check(2'd1, f3[i], case_name[i]);
		end else if (op != 2'b00 || ext == 2'b01 || ext == 2'b10) begin
			// Busy low followed by ready high
			while (ee_do !== 1'b0) @(negedge sys_clk);
			while (ee_do !== 1'b1) @(negedge sys_clk);
		end
		@(negedge sys_clk);
		ee.sk = 1'b0;
		ee.cs = 1'b0;
		repeat (3) @(negedge sys_clk);
	endtask

	task automatic adc_case(input int i);
		analog  = f1[i];
		adc_sel = f2[i][3:0];
		adc_wr  = 1'b1;
		@(negedge sys_clk);
		adc_wr = 1'b0;
		@(negedge sys_clk);
		check(2'd2, f3[i], case_name[i]);
	endtask

	task automatic i2s_clock(input logic ws, input logic sd);
		@(negedge sys_clk);
		i2s.sck = 1'b0;
		i2s.ws  = ws;
		i2s.sd  = sd;
		repeat (4) @(negedge sys_clk);
		i2s.sck = 1'b1;
		repeat (3) @(negedge sys_clk);
	endtask

	task automatic aud_case(input int i);
		aud_en_d  = f1[i][0];
		aud_en_wr = 1'b1;
		@(negedge sys_clk);
		aud_en_wr = 1'b0;
		repeat (2) @(negedge sys_clk);
		repeat (2) i2s_clock(1'b1, 1'b0);    // Right first so left is a change
		repeat (2) i2s_clock(1'b0, 1'b0);
		for (int k = 31; k >= 16; k--) i2s_clock(1'b0, f2[i][k]);
		repeat (2) i2s_clock(1'b1, 1'b0);
		for (int k = 15; k >= 0; k--) i2s_clock(1'b1, f2[i][k]);
		repeat (2) i2s_clock(1'b0, 1'b0);    // ws low again closes the frame
		repeat (2) @(negedge sys_clk);
		check(2'd3, f3[i], case_name[i]);
	endtask

	initial begin
		cycles = 0;
		issued = 0;
		setup_errors = 0;
		xresetl = 1'b0;
		ee = '0;
		adc_wr = 1'b0;
		adc_sel = '0;
		analog = '0;
		aud_en_wr = 1'b0;
		aud_en_d = 1'b0;
		i2s = '0;
		ee_bit = 1'b0;
		chk = 1'b0;
		chk_kind = '0;
		chk_exp = '0;
		chk_name = '0;
		load_cases();
		limit = n_cases * 1200 + 100;
		repeat (3) @(negedge sys_clk);
		xresetl = 1'b1;
		@(negedge sys_clk);
		check(2'd0, 32'd1, "reset_ee_do");
		check(2'd2, 32'd0, "reset_adc");
		check(2'd3, 32'd0, "reset_audio");
		for (int i = 0; i < n_cases; i++) begin
			if (case_kind[i] == "EE") begin
				ee_case(i);
			end else if (case_kind[i] == "ADC") begin
				adc_case(i);
			end else if (case_kind[i] == "AUD") begin
				aud_case(i);
			end else begin
				$display("Unknown case kind in case %0d", i);
				setup_errors++;
			end
		end
		repeat (4) @(negedge sys_clk);
		if (checks != issued) begin
			$display("Checker compared %0d values but %0d were requested", checks, issued);
		end
		$display("Checks: %0d  errors: %0d  setup errors: %0d  cases: %0d",
			checks, errors, setup_errors, n_cases);
		if (errors == 0 && setup_errors == 0 && checks == issued) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hdl/jag_pkg.sv
hdl/ee_word_store.sv
hdl/ee_serial_ctrl.sv
hdl/analog_adc.sv
hdl/audio_enable_gate.sv
hdl/i2s_capture.sv
hdl/jag_periph_top.sv
testbench/jag_periph_checker.sv
testbench/tb_jag_periph.sv

//--- testbench/periph_cases.txt
# name kind f1 f2 f3 (hex); EE: instruction, write data, expected read word
# ADC: ch0..ch3, select, expected; AUD: enable, left and right, expected audio
wp_write EE 145 1234 0
wp_read EE 185 0 FFFF
ewen EE 130 0 0
write_5 EE 145 A5C3 0
read_5 EE 185 0 A5C3
erase_5 EE 1C5 0 0
read_5_erased EE 185 0 FFFF
wral EE 110 5A0F 0
read_wral_00 EE 180 0 5A0F
read_wral_3f EE 1BF 0 5A0F
eral EE 120 0 0
read_eral_17 EE 197 0 FFFF
read_eral_3f EE 1BF 0 FFFF
adc_m0_c0 ADC 80301050 0 50
adc_m0_c1 ADC 80301050 1 0
adc_m0_c2 ADC 80301050 2 0
adc_m0_c3 ADC 80301050 3 40
adc_m1_c0 ADC 80301050 4 80
adc_m1_c3 ADC 80301050 7 50
adc_m2_c1 ADC 20301050 9 10
adc_m3_c0 ADC 80301050 C 30
adc_m3_hold ADC 11111111 F 30
adc_m3_c1 ADC 80301050 D 0
aud_off AUD 0 12348765 0
aud_on AUD 1 CAFE0BEE CAFE0BEE
